//--- compile.f
+incdir+hdl
hdl/kmul_pkg.sv
hdl/kmul_sequencer.sv
hdl/kmul_operand_path.sv
hdl/kmul_accumulator.sv
hdl/kmul_top.sv
testbench/kmul_tb.sv

//--- Makefile
SIM      := verilator
TOP      := kmul_tb
FILELIST := compile.f
FLAGS    := --binary --timing -Wno-fatal --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))
HEADERS  := hdl/kmul_cfg.svh

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the log holds the pass message
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/kmul_tb.sv
// needs one reset per vector since the DUT has no handshake and enable acts as a level
`timescale 1ns/1ns
`include "kmul_cfg.svh"

module kmul_tb;

    import kmul_pkg::*;

    // ------------------------------
    // vector table
    // ------------------------------

    localparam int NUM_CORNER  = 10;
    localparam int NUM_RANDOM  = 40;
    localparam int NUM_VEC     = NUM_CORNER + NUM_RANDOM;
    // edges allowed before done counts as lost
    localparam int DONE_LIMIT  = 32;
    localparam int HOLD_CYCLES = 8;
    localparam int RST_CYCLES  = 5;

    // operands plus enable-low cycles after the first step
    typedef struct packed {
        logic [`KMUL_WIDTH-1:0] a;
        logic [`KMUL_WIDTH-1:0] b;
        logic [1:0]             pause;
    } vec_t;

    vec_t vec_tab [NUM_VEC];

    // DUT signals
    logic                        clk;
    logic                        rst;
    logic                        enable;
    operand_u                    a;
    operand_u                    b;
    logic [`KMUL_PROD_WIDTH-1:0] product;
    logic                        done;

    kmul_top kmul_top_inst (
        .clk     (clk),
        .rst     (rst),
        .enable  (enable),
        .a       (a),
        .b       (b),
        .product (product),
        .done    (done)
    );

    // 10 ns period
    always #5 clk = ~clk;

    // ------------------------------
    // checking helpers
    // ------------------------------

    task automatic fail_run(input string msg);
        $display("TB FAILED");
        $display("%s", msg);
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            fail_run($sformatf("error at %0t ns: %s expected %h, got %h",
                               $time, name, expected, actual));
        end
    endtask

    // holds reset for 5 cycles while outputs must read zero
    task automatic start_operation(input vec_t vec);
        int i;
        rst    = 1'b1;
        enable = 1'b1;
        a.word = vec.a;
        b.word = vec.b;
        for (i = 0; i < RST_CYCLES; i++) begin
            @(posedge clk);
            #1;
            check_value("done", 64'd0, 64'(done));
            check_value("product", 64'd0, product);
        end
        rst = 1'b0;
    endtask

    // counts edges after reset until done with the pause inserted after edge 1
    task automatic run_to_done(input vec_t vec, input logic [63:0] expected);
        int edges;
        edges = 0;
        while (!done) begin
            @(posedge clk);
            #1;
            edges++;
            // first edge out of reset only leaves idle
            if (edges == 1) begin
                check_value("done", 64'd0, 64'(done));
                check_value("product", 64'd0, product);
            end
            if (edges == 1 && vec.pause != 2'd0) begin
                enable = 1'b0;
            end
            if (edges == 1 + int'(vec.pause) && vec.pause != 2'd0) begin
                enable = 1'b1;
            end
            if (edges > DONE_LIMIT) begin
                fail_run($sformatf("timeout at %0t ns: done never rose for a=%h b=%h",
                                   $time, vec.a, vec.b));
            end
        end
        // latency is 4 enabled edges plus the pause
        check_value("done_edge", 64'(4 + int'(vec.pause)), 64'(edges));
        check_value("product", expected, product);
    endtask

    // done and product frozen while enable stays high
    task automatic check_hold(input logic [63:0] expected);
        int i;
        for (i = 0; i < HOLD_CYCLES; i++) begin
            @(posedge clk);
            #1;
            check_value("done", 64'd1, 64'(done));
            check_value("product", expected, product);
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------

    initial begin
        int          idx;
        logic [63:0] expected;
        void'($urandom(32'h4411));
        clk    = 1'b0;
        rst    = 1'b1;
        enable = 1'b0;
        a      = '0;
        b      = '0;

        // extremes
        vec_tab[0] = '{a: 32'h0000_0000, b: 32'h0000_0000, pause: 2'd0};
        vec_tab[1] = '{a: 32'hffff_ffff, b: 32'hffff_ffff, pause: 2'd0};
        vec_tab[2] = '{a: 32'h0000_0000, b: 32'hffff_ffff, pause: 2'd1};
        // zero differences
        vec_tab[3] = '{a: 32'hffff_ffff, b: 32'h0000_0001, pause: 2'd0};
        vec_tab[4] = '{a: 32'h1234_1234, b: 32'habcd_abcd, pause: 2'd2};
        // same signs so the middle product is subtracted
        vec_tab[5] = '{a: 32'h8000_0001, b: 32'h00ff_0001, pause: 2'd0};
        vec_tab[6] = '{a: 32'h0001_ffff, b: 32'h1234_abcd, pause: 2'd1};
        vec_tab[9] = '{a: 32'h7fff_8000, b: 32'h0001_8000, pause: 2'd2};
        // opposite signs add the middle product
        vec_tab[7] = '{a: 32'hffff_0001, b: 32'h0001_ffff, pause: 2'd3};
        vec_tab[8] = '{a: 32'h0000_ffff, b: 32'hffff_0000, pause: 2'd0};

        for (idx = NUM_CORNER; idx < NUM_VEC; idx++) begin
            vec_tab[idx].a     = $urandom();
            vec_tab[idx].b     = $urandom();
            vec_tab[idx].pause = 2'($urandom());
        end

        @(posedge clk);
        #1;
        for (idx = 0; idx < NUM_VEC; idx++) begin
            // reference is a plain 64 bit multiply
            expected = {32'd0, vec_tab[idx].a} * {32'd0, vec_tab[idx].b};
            start_operation(vec_tab[idx]);
            run_to_done(vec_tab[idx], expected);
            check_hold(expected);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- hdl/kmul_top.sv
// one operation per reset, operands must stay stable until done rises
`timescale 1ns/1ns
`include "kmul_cfg.svh"

module kmul_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         enable,
    input  kmul_pkg::operand_u           a,
    input  kmul_pkg::operand_u           b,
    output logic [`KMUL_PROD_WIDTH-1:0]  product,
    output logic                         done
);

    import kmul_pkg::*;

    // ------------------------------
    // internal wiring
    // ------------------------------

    // current step, one-hot
    step_e step;
    // accumulators load on this
    logic  acc_en;
    // partial product of the current step
    pp_t   pp;

    // step machine
    kmul_sequencer kmul_sequencer_inst (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .step   (step),
        .acc_en (acc_en),
        .done   (done)
    );

    // half split, differences and the one 16x16 multiply
    kmul_operand_path kmul_operand_path_inst (
        .a    (a),
        .b    (b),
        .step (step),
        .pp   (pp)
    );

    // middle and result registers
    kmul_accumulator kmul_accumulator_inst (
        .clk     (clk),
        .rst     (rst),
        .step    (step),
        .acc_en  (acc_en),
        .pp      (pp),
        .product (product)
    );

endmodule

//--- hdl/kmul_accumulator.sv
// registers load only with acc_en high, product is valid once the sequencer reports done
`timescale 1ns/1ns
`include "kmul_cfg.svh"

module kmul_accumulator (
    input  logic                         clk,
    input  logic                         rst,
    input  kmul_pkg::step_e              step,
    input  logic                         acc_en,
    input  kmul_pkg::pp_t                pp,
    output logic [`KMUL_PROD_WIDTH-1:0]  product
);

    import kmul_pkg::*;

    // ------------------------------
    // middle term
    // ------------------------------

    // collects lo*lo + hi*hi, then the signed difference product
    logic [`KMUL_MID_WIDTH-1:0] mid_q;
    logic [`KMUL_MID_WIDTH-1:0] mid_sum;
    logic [`KMUL_MID_WIDTH-1:0] pp_ext;

    assign pp_ext = {1'b0, pp.product};

    // final middle value is never negative
    assign mid_sum = pp.negate ? (mid_q - pp_ext) : (mid_q + pp_ext);

    // ------------------------------
    // result
    // ------------------------------

    logic [`KMUL_PROD_WIDTH-1:0] res_q;
    logic [`KMUL_PROD_WIDTH-1:0] res_term;
    logic [`KMUL_PROD_WIDTH-1:0] res_sum;

    // fixed shifts per step, plain wiring
    always_comb begin
        case (step)
            STEP_LOW: begin
                res_term = {{`KMUL_WIDTH{1'b0}}, pp.product};
            end
            STEP_HIGH: begin
                res_term = {pp.product, {`KMUL_WIDTH{1'b0}}};
            end
            // fresh middle sum, not the registered one
            STEP_MID: begin
                res_term = {{(`KMUL_PROD_WIDTH-`KMUL_MID_WIDTH-`KMUL_HALF){1'b0}},
                            mid_sum, {`KMUL_HALF{1'b0}}};
            end
            default: begin
                res_term = '0;
            end
        endcase
    end

    assign res_sum = res_q + res_term;

    // both accumulators step together
    always_ff @(posedge clk) begin
        if (rst) begin
            mid_q <= '0;
            res_q <= '0;
        end else if (acc_en) begin
            mid_q <= mid_sum;
            res_q <= res_sum;
        end
    end

    assign product = res_q;

endmodule

//--- hdl/kmul_operand_path.sv
// purely combinational, the partial product follows step in the same cycle
`timescale 1ns/1ns
`include "kmul_cfg.svh"

module kmul_operand_path (
    input  kmul_pkg::operand_u a,
    input  kmul_pkg::operand_u b,
    input  kmul_pkg::step_e    step,
    output kmul_pkg::pp_t      pp
);

    import kmul_pkg::*;

    // difference hi - lo as borrow bit over a 16 bit magnitude
    function automatic logic [`KMUL_HALF:0] diff_mag(input half_t hi, input half_t lo);
        logic [`KMUL_HALF:0] diff;
        half_t               mag;
        diff = {1'b0, hi} - {1'b0, lo};
        // borrow set means lo above hi, so negate the low bits
        if (diff[`KMUL_HALF]) begin
            mag = ~diff[`KMUL_HALF-1:0] + 1'b1;
        end else begin
            mag = diff[`KMUL_HALF-1:0];
        end
        return {diff[`KMUL_HALF], mag};
    endfunction

    // ------------------------------
    // half split
    // ------------------------------

    half_t hi_a;
    half_t lo_a;
    half_t hi_b;
    half_t lo_b;

    assign hi_a = a.half.hi;
    assign lo_a = a.half.lo;
    assign hi_b = b.half.hi;
    assign lo_b = b.half.lo;

    // magnitudes and signs of both differences
    logic  borrow_a;
    logic  borrow_b;
    half_t mag_a;
    half_t mag_b;

    assign {borrow_a, mag_a} = diff_mag(hi_a, lo_a);
    assign {borrow_b, mag_b} = diff_mag(hi_b, lo_b);

    // ------------------------------
    // shared multiplier
    // ------------------------------

    half_t                  mul_x;
    half_t                  mul_y;
    logic [`KMUL_WIDTH-1:0] mul_p;

    // idle and done feed zeros
    always_comb begin
        mul_x = '0;
        mul_y = '0;
        case (step)
            STEP_LOW: begin
                mul_x = lo_a;
                mul_y = lo_b;
            end
            STEP_HIGH: begin
                mul_x = hi_a;
                mul_y = hi_b;
            end
            STEP_MID: begin
                mul_x = mag_a;
                mul_y = mag_b;
            end
            default: begin
                mul_x = '0;
                mul_y = '0;
            end
        endcase
    end

    assign mul_p = mul_x * mul_y;

    // signed difference product is positive here, so it comes off the middle sum
    assign pp.product = mul_p;
    assign pp.negate  = (step == STEP_MID) && (|mag_a) && (|mag_b) && (borrow_a == borrow_b);

endmodule

//--- hdl/kmul_sequencer.sv
// advances one step per edge with enable high and holds in done until the next reset
`timescale 1ns/1ns

module kmul_sequencer (
    input  logic            clk,
    input  logic            rst,
    input  logic            enable,
    output kmul_pkg::step_e step,
    output logic            acc_en,
    output logic            done
);

    import kmul_pkg::*;

    // ------------------------------
    // state register
    // ------------------------------

    step_e state_q;
    step_e state_d;

    // order is idle, low, high, mid, done
    always_comb begin
        case (state_q)
            STEP_IDLE: begin
                state_d = STEP_LOW;
            end
            STEP_LOW: begin
                state_d = STEP_HIGH;
            end
            STEP_HIGH: begin
                state_d = STEP_MID;
            end
            STEP_MID: begin
                state_d = STEP_DONE;
            end
            // terminal, only reset leaves it
            STEP_DONE: begin
                state_d = STEP_DONE;
            end
            // illegal one-hot code
            default: begin
                state_d = STEP_IDLE;
            end
        endcase
    end

    // enable low freezes the step
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= STEP_IDLE;
        end else if (enable) begin
            state_q <= state_d;
        end
    end

    // ------------------------------
    // outputs
    // ------------------------------

    // step code goes straight to the datapath
    assign step = state_q;

    // no accumulation once finished
    assign acc_en = enable && (state_q != STEP_DONE);

    // level, held until reset
    assign done = (state_q == STEP_DONE);

endmodule

//--- hdl/kmul_pkg.sv
// shared types for the 32 bit karatsuba multiplier, no other operand width is supported
`include "kmul_cfg.svh"

package kmul_pkg;

    // ------------------------------
    // operand types
    // ------------------------------

    // one unsigned half of an operand
    typedef logic [`KMUL_HALF-1:0] half_t;

    // same operand word seen whole or as hi/lo halves
    typedef union packed {
        logic [`KMUL_WIDTH-1:0] word;
        struct packed {
            half_t hi;
            half_t lo;
        } half;
    } operand_u;

    // ------------------------------
    // sequencer steps
    // ------------------------------

    // one-hot, idle step first
    typedef enum logic [4:0] {
        STEP_IDLE = 5'b00001,
        STEP_LOW  = 5'b00010,
        STEP_HIGH = 5'b00100,
        STEP_MID  = 5'b01000,
        STEP_DONE = 5'b10000
    } step_e;

    // partial product handed to the accumulator
    typedef struct packed {
        // output of the shared 16x16 multiplier
        logic [`KMUL_WIDTH-1:0] product;
        // subtract from the middle term instead of adding
        logic                   negate;
    } pp_t;

endpackage

//--- hdl/kmul_cfg.svh
// widths are fixed at 32 by 32 and the datapath is only correct for the values below
`ifndef KMUL_CFG_SVH
`define KMUL_CFG_SVH

// ------------------------------
// operand and result widths
// ------------------------------

// full operand word
`define KMUL_WIDTH 32
// one half of an operand, also the shared multiplier input width
`define KMUL_HALF 16
// middle term register, one bit above a full half product
`define KMUL_MID_WIDTH 33
// final product register
`define KMUL_PROD_WIDTH 64

`endif
